/* hw/spi_settings.svh */
////////////////////////////////////////
// Build-time settings for the SPI bridge.
// Divider width and request queue depth.
////////////////////////////////////////

`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// SCLK runs at clk divided by two to this power.
// The default of 5 gives divide-by-32.
`define SPI_CLK_DIV_W 5

// Entries in the request queue.
// This is also the credit count the host holds after reset.
`define SPI_REQ_DEPTH 4

`endif

/* hw/spi_link_pkg.sv */
////////////////////////////////////////
// SPI link types.
// Frame layout and monarch FSM states.
////////////////////////////////////////

package spi_link_pkg;

  ////////////////////////////////////////
  // Frame on the wire
  ////////////////////////////////////////

  // One 16-bit frame, sent MSB first.
  typedef struct packed {
    logic       rd;   // Bit 15. High for a register read.
    logic [6:0] addr; // Bits 14 to 8. Register address in the serf.
    logic [7:0] data; // Bits 7 to 0. Write data, don't care on a read.
  } frame_t;

  ////////////////////////////////////////
  // Monarch FSM
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    ST_IDLE,      // SS_n high, waiting for snd.
    ST_TRMT,      // Shifting the 16 bits of the frame.
    ST_BACK_PORCH // Last SCLK high phase before SS_n rises.
  } monarch_state_t;

endpackage

/* hw/host_req_pkg.sv */
////////////////////////////////////////
// Host request interface types.
// Opcodes, request and response.
////////////////////////////////////////

package host_req_pkg;

  // Register access type requested by the host.
  typedef enum logic {
    OP_WR = 1'b0, // Register write.
    OP_RD = 1'b1  // Register read.
  } opcode_t;

  ////////////////////////////////////////
  // Request and response payloads
  ////////////////////////////////////////

  // One host request, 16 bits.
  typedef struct packed {
    opcode_t    op;   // Read or write.
    logic [6:0] addr; // Serf register address.
    logic [7:0] data; // Write data, ignored on reads.
  } req_t;

  // One response, 24 bits, returned in request order.
  typedef struct packed {
    opcode_t     op;   // Echo of the request opcode.
    logic [6:0]  addr; // Echo of the request address.
    logic [15:0] word; // Full word captured from MISO.
  } rsp_t;

endpackage

/* hw/spi_monarch.sv */
////////////////////////////////////////
// SPI monarch transceiver.
// Shifts one 16-bit frame out on MOSI
// while capturing 16 bits from MISO.
////////////////////////////////////////

`timescale 1ns/1ps

`include "spi_settings.svh"

module spi_monarch (
  input  logic                  clk,   // System clock.
  input  logic                  rst_n, // Asynchronous active low reset.
  input  logic                  miso,  // Serial data from the serf.
  input  logic                  snd,   // One-cycle pulse that starts a frame.
  input  spi_link_pkg::frame_t  cmd,   // Frame to send, sampled with snd.
  output logic                  ss_n,  // Serf select, active low.
  output logic                  sclk,  // Serial clock, idles high.
  output logic                  mosi,  // Serial data to the serf.
  output logic                  done,  // High from end of frame until the next snd.
  output logic [15:0]           resp   // Captured word, valid while done is high.
);

  localparam int DIV_W = `SPI_CLK_DIV_W;

  // Preload is 10 followed by ones, so SCLK stays high a few clocks after SS_n falls.
  localparam logic [DIV_W-1:0] DIV_PRELOAD = {2'b10, {(DIV_W-2){1'b1}}};
  localparam logic [DIV_W-1:0] DIV_SHIFT   = {1'b1, {(DIV_W-2){1'b0}}, 1'b1}; // Two clocks past rise.
  localparam logic [DIV_W-1:0] DIV_FULL    = '1; // SCLK about to fall.

  spi_link_pkg::monarch_state_t state;     // Current FSM state.
  spi_link_pkg::monarch_state_t nxt_state; // Next FSM state.

  logic [15:0]      shft_reg; // Out on MOSI from the top, in from MISO at the bottom.
  logic [DIV_W-1:0] sclk_div; // Free-running divider, MSB is SCLK.
  logic [4:0]       bit_cnt;  // Bits shifted so far in this frame.
  logic             init;     // Start of a frame.
  logic             ld_sclk;  // Hold the divider at its preload.
  logic             shift;    // Shift one bit this cycle.
  logic             full;     // Divider has wrapped to all ones.
  logic             done16;   // All 16 bits are in.
  logic             set_done; // Frame is over.

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (init) begin
      shft_reg <= cmd;                      // Parallel load of the outgoing frame.
    end else if (shift) begin
      shft_reg <= {shft_reg[14:0], miso};   // MSB goes out, MISO comes in.
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      sclk_div <= DIV_PRELOAD;               // SCLK high out of reset.
    end else if (ld_sclk) begin
      sclk_div <= DIV_PRELOAD;
    end else begin
      sclk_div <= sclk_div + 1'b1;           // Divider runs freely during a frame.
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (init) begin
      bit_cnt <= '0;                         // New frame, no bits yet.
    end else if (shift) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  assign sclk   = sclk_div[DIV_W-1];         // SCLK is the divider MSB.
  assign shift  = (sclk_div == DIV_SHIFT);   // Sample MISO two clocks after SCLK rises.
  assign full   = (sclk_div == DIV_FULL);
  assign done16 = (bit_cnt == 5'd16);
  assign mosi   = shft_reg[15];
  assign resp   = shft_reg;                  // Whole register is the reply.

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  // Set/reset flops so SS_n and done never glitch.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ss_n <= 1'b1;
      done <= 1'b0;
    end else if (init) begin
      ss_n <= 1'b0;                          // Select the serf one cycle after snd.
      done <= 1'b0;
    end else if (set_done) begin
      ss_n <= 1'b1;                          // Deselect in the same cycle done rises.
      done <= 1'b1;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= spi_link_pkg::ST_IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    nxt_state = state;                       // Stay put by default.
    init      = 1'b0;
    ld_sclk   = 1'b0;
    set_done  = 1'b0;
    case (state)
      spi_link_pkg::ST_TRMT: begin
        if (done16) begin
          nxt_state = spi_link_pkg::ST_BACK_PORCH; // Let SCLK finish its high phase.
        end
      end
      spi_link_pkg::ST_BACK_PORCH: begin
        if (full) begin
          set_done  = 1'b1;                  // End the frame before SCLK would fall.
          ld_sclk   = 1'b1;
          nxt_state = spi_link_pkg::ST_IDLE;
        end
      end
      default: begin
        ld_sclk = 1'b1;                      // Keep SCLK parked high while idle.
        if (snd) begin
          init      = 1'b1;
          nxt_state = spi_link_pkg::ST_TRMT;
        end
      end
    endcase
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Idle FSM and a selected serf must never coexist.
  a_idle_deselected: assert property (@(posedge clk) disable iff (!rst_n)
    (state == spi_link_pkg::ST_IDLE) |-> ss_n)
    else $error("ss_n low while monarch idle");

  // The sequencer keeps one frame on the wire, so no start request mid-frame.
  a_no_snd_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (state != spi_link_pkg::ST_IDLE) |-> !snd)
    else $error("snd seen during an active frame");

endmodule

/* hw/req_queue.sv */
////////////////////////////////////////
// Host request FIFO.
// Returns one credit per released entry.
////////////////////////////////////////

`timescale 1ns/1ps

`include "spi_settings.svh"

module req_queue (
  input  logic                clk,           // System clock.
  input  logic                rst_n,         // Asynchronous active low reset.
  input  logic                push,          // Host writes push_data this cycle.
  input  host_req_pkg::req_t  push_data,     // Incoming request.
  input  logic                pop,           // Sequencer takes the head.
  output host_req_pkg::req_t  head,          // Oldest queued request.
  output logic                not_empty,     // At least one request waits.
  output logic                credit_return  // One credit back to the host.
);

  localparam int DEPTH = `SPI_REQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  host_req_pkg::req_t mem [DEPTH]; // Entry storage.
  logic [PTR_W-1:0]   wr_ptr;      // Next slot to fill.
  logic [PTR_W-1:0]   rd_ptr;      // Slot holding the head.
  logic [CNT_W-1:0]   count;       // Entries currently held.
  logic               full;        // No free slot.
  logic               do_pop;      // An entry leaves this cycle.

  assign full          = (count == CNT_W'(DEPTH));
  assign not_empty     = (count != '0);
  assign do_pop        = pop & not_empty;
  assign credit_return = do_pop;        // Credit goes back in the same cycle as the pop.
  assign head          = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(do_pop); // Net occupancy change.
    end
  end

  // The host spent a credit it did not have.
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) full |-> !push)
    else $error("push into a full request queue");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !not_empty |-> !pop)
    else $error("pop from an empty request queue");

endmodule

/* hw/spi_sequencer.sv */
////////////////////////////////////////
// Request sequencer.
// Request to frame, monarch start and
// response formation.
////////////////////////////////////////

`timescale 1ns/1ps

module spi_sequencer (
  input  logic                  clk,       // System clock.
  input  logic                  rst_n,     // Asynchronous active low reset.
  input  host_req_pkg::req_t    head,      // Oldest queued request.
  input  logic                  not_empty, // Queue holds a request.
  output logic                  pop,       // Take the head this cycle.
  output logic                  snd,       // Start the monarch.
  output spi_link_pkg::frame_t  cmd,       // Frame for the monarch.
  input  logic                  done,      // Monarch frame complete.
  input  logic [15:0]           resp,      // Word captured from MISO.
  output logic                  rsp_valid, // One-cycle response strobe.
  output host_req_pkg::rsp_t    rsp        // Response payload.
);

  typedef enum logic [1:0] {
    SEQ_IDLE, // Waiting for a queued request.
    SEQ_SEND, // Frame loaded, pulse snd.
    SEQ_WAIT  // Frame on the wire.
  } seq_state_t;

  seq_state_t            state;    // Current FSM state.
  host_req_pkg::opcode_t op_q;     // Opcode of the frame in flight.
  logic                  done_q;   // done delayed by one cycle.
  logic                  done_rise; // Frame just ended.

  assign pop       = (state == SEQ_IDLE) && not_empty; // Only one frame at a time.
  assign snd       = (state == SEQ_SEND);
  assign done_rise = (state == SEQ_WAIT) && done && !done_q;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state     <= SEQ_IDLE;
      done_q    <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      done_q    <= done;
      rsp_valid <= done_rise;             // Response one cycle after done rises.
      case (state)
        SEQ_IDLE: if (not_empty) state <= SEQ_SEND;
        SEQ_SEND: state <= SEQ_WAIT;
        SEQ_WAIT: if (done_rise) state <= SEQ_IDLE;
        default:  state <= SEQ_IDLE;
      endcase
    end
  end

  // Frame and in-flight tags are payload, loaded with the pop.
  always_ff @(posedge clk) begin
    if (pop) begin
      op_q     <= head.op;
      cmd.rd   <= (head.op == host_req_pkg::OP_RD); // Read opcode sets the read flag.
      cmd.addr <= head.addr;
      cmd.data <= head.data;
    end
  end

  // Capture the reply while done still holds resp steady.
  always_ff @(posedge clk) begin
    if (done_rise) begin
      rsp.op   <= op_q;
      rsp.addr <= cmd.addr;
      rsp.word <= resp;
    end
  end

endmodule

/* hw/spi_bridge_top.sv */
////////////////////////////////////////
// SPI bridge top level.
// Request queue, sequencer and monarch.
////////////////////////////////////////

`timescale 1ns/1ps

module spi_bridge_top (
  input  logic                clk,           // System clock.
  input  logic                rst_n,         // Asynchronous active low reset.
  input  logic                req_valid,     // Host request strobe, costs one credit.
  input  host_req_pkg::req_t  req,           // Host request.
  output logic                credit_return, // One credit back to the host.
  output logic                rsp_valid,     // Response strobe.
  output host_req_pkg::rsp_t  rsp,           // Response payload.
  output logic                ss_n,          // SPI serf select.
  output logic                sclk,          // SPI clock.
  output logic                mosi,          // SPI data out.
  input  logic                miso           // SPI data in.
);

  host_req_pkg::req_t   head;      // Queue head to the sequencer.
  logic                 not_empty; // Queue has work.
  logic                 pop;       // Sequencer takes the head.
  logic                 snd;       // Frame start.
  spi_link_pkg::frame_t cmd;       // Frame to shift out.
  logic                 done;      // Frame finished.
  logic [15:0]          resp;      // Captured MISO word.

  req_queue req_queue_i (
    .clk, .rst_n, .push(req_valid), .push_data(req), .pop, .head, .not_empty, .credit_return
  );

  spi_sequencer spi_sequencer_i (
    .clk, .rst_n, .head, .not_empty, .pop, .snd, .cmd, .done, .resp, .rsp_valid, .rsp
  );

  spi_monarch spi_monarch_i (
    .clk, .rst_n, .miso, .snd, .cmd, .ss_n, .sclk, .mosi, .done, .resp
  );

endmodule

/* tests/spi_serf_model.sv */
////////////////////////////////////////
// Behavioral SPI sensor serf.
// 128 byte registers, 16-bit frames,
// MOSI sampled on SCLK rise, MISO on fall.
////////////////////////////////////////

`timescale 1ns/1ps

module spi_serf_model (
  input  logic        ss_n,     // Serf select from the monarch, active low.
  input  logic        sclk,     // Serial clock, idles high.
  input  logic        mosi,     // Serial data from the monarch.
  output logic        miso,     // Serial data to the monarch.
  output logic [15:0] rx_frame  // Last complete frame seen on MOSI.
);

  logic [7:0]  regs [128]; // Sensor register file.
  logic [15:0] rx_sr;      // MOSI shift register, MSB arrives first.
  logic [15:0] tx_sr;      // MISO shift register, MSB goes out first.

  assign miso = tx_sr[15];

  ////////////////////////////////////////
  // Frame handling
  ////////////////////////////////////////

  initial begin
    for (int i = 0; i < 128; i++) begin
      regs[i] = 8'h00;                      // Registers power up cleared.
    end
    rx_sr    = '0;
    tx_sr    = '0;
    rx_frame = '0;
    forever begin
      @(negedge ss_n);
      tx_sr = '0;                           // High byte of every reply is zero.
      for (int bit_idx = 0; bit_idx < 16; bit_idx++) begin
        @(negedge sclk);
        if (bit_idx == 8) begin
          // Read flag and address are in, so the old register value goes out next.
          tx_sr = {regs[rx_sr[6:0]], 8'h00};
        end else if (bit_idx != 0) begin
          tx_sr = {tx_sr[14:0], 1'b0};      // Present the next bit while SCLK is low.
        end
        @(posedge sclk);
        rx_sr = {rx_sr[14:0], mosi};        // MOSI is stable across the rising edge.
      end
      @(posedge ss_n);
      rx_frame = rx_sr;                     // Whole frame for the testbench to compare.
      if (!rx_sr[15]) begin
        regs[rx_sr[14:8]] = rx_sr[7:0];     // A write lands at the end of the frame.
      end
    end
  end

endmodule

/* tests/tb_spi_bridge.sv */
////////////////////////////////////////
// Testbench for the SPI bridge.
// Clock, reset, LCG stimulus, reference
// registers, assertions and watchdog.
////////////////////////////////////////

`timescale 1ns/1ps

`include "spi_settings.svh"

module tb_spi_bridge;

  localparam int DEPTH        = `SPI_REQ_DEPTH;
  localparam int CLK_PERIOD   = 100;                         // In ns.
  localparam int NUM_BURSTS   = 12;
  localparam int NUM_REQS     = NUM_BURSTS * DEPTH;
  localparam int FRAME_CYCLES = 18 * (1 << `SPI_CLK_DIV_W);  // Setup, 16 bits and porch.
  localparam longint WATCHDOG_NS = (longint'(NUM_REQS) * FRAME_CYCLES + 200) * CLK_PERIOD;

  // One outstanding request as the host expects to see it come back.
  typedef struct packed {
    host_req_pkg::rsp_t rsp;   // Expected response payload.
    logic [15:0]        frame; // Expected word on MOSI.
  } expect_t;

  logic               clk;
  logic               rst_n;
  logic               req_valid;
  host_req_pkg::req_t req;
  logic               credit_return;
  logic               rsp_valid;
  host_req_pkg::rsp_t rsp;
  logic               ss_n;
  logic               sclk;
  logic               mosi;
  logic               miso;
  logic [15:0]        serf_frame;    // Frame the serf captured last.

  logic        reset_applied;        // Checks stay quiet until reset has taken effect.
  logic [31:0] lcg_state;
  logic [7:0]  ref_regs [128];       // What the serf registers should hold.
  expect_t     exp_q [$];            // Outstanding requests, oldest first.
  logic        credit_due;           // Credit seen last cycle, usable from now on.
  int          credits;
  int          sent_total;
  int          returned_total;
  int          reset_errs;
  int          link_errs;
  int          rsp_errs;
  int          credit_errs;

  spi_bridge_top spi_bridge_top_i (
    .clk, .rst_n, .req_valid, .req, .credit_return, .rsp_valid, .rsp,
    .ss_n, .sclk, .mosi, .miso
  );

  spi_serf_model spi_serf_model_i (
    .ss_n, .sclk, .mosi, .miso, .rx_frame(serf_frame)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the bridge did not answer every request in time.");
    $display("Test failures found");
    $finish;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Read flag on top, then the address, then the data byte.
  function automatic logic [15:0] frame_of(input host_req_pkg::req_t r);
    return {r.op == host_req_pkg::OP_RD, r.addr, r.data};
  endfunction

  task automatic next_cycle();
    @(negedge clk);
    req_valid = 1'b0;
    if (credit_due) credits++;                 // Slot was freed at the last rising edge.
    credit_due = credit_return;
    if (credit_return) returned_total++;
  endtask

  task automatic send_request(input logic [31:0] rnd);
    host_req_pkg::req_t r;
    expect_t            e;
    r.op   = host_req_pkg::opcode_t'(rnd[31]);
    r.addr = rnd[24] ? rnd[22:16] : {3'b000, rnd[19:16]}; // Small window, so reads hit writes.
    r.data = rnd[15:8];
    e.rsp.op   = r.op;
    e.rsp.addr = r.addr;
    e.rsp.word = {8'h00, ref_regs[r.addr]};   // Serf replies with the value before the frame.
    e.frame    = frame_of(r);
    if (r.op == host_req_pkg::OP_WR) ref_regs[r.addr] = r.data;
    exp_q.push_back(e);
    req       = r;
    req_valid = 1'b1;
    credits--;
    sent_total++;
  endtask

  task automatic check_response();
    expect_t e;
    if (exp_q.size() == 0) begin
      rsp_errs++;
      $display("A response arrived at %0t ns with no request outstanding.", $time);
    end else begin
      e = exp_q.pop_front();
      a_rsp_match: assert (rsp == e.rsp) else begin
        rsp_errs++;
        $display("ERROR at %0t ns: got op %0d addr 0x%02h word 0x%04h, expected %0d 0x%02h 0x%04h",
                 $time, rsp.op, rsp.addr, rsp.word, e.rsp.op, e.rsp.addr, e.rsp.word);
      end
      a_frame_match: assert (serf_frame == e.frame) else begin
        link_errs++;
        $display("ERROR at %0t ns: serf saw frame 0x%04h, expected 0x%04h",
                 $time, serf_frame, e.frame);
      end
    end
  endtask

  always @(negedge clk) begin
    if (reset_applied && rst_n && rsp_valid) check_response();
  end

  ////////////////////////////////////////
  // Concurrent checks
  ////////////////////////////////////////

  a_reset_values: assert property (@(posedge clk)
    (reset_applied && (!rst_n || $rose(rst_n))) |-> (ss_n && sclk && !rsp_valid && !credit_return))
    else begin
      reset_errs++;
      $display("ERROR at %0t ns: outputs not at their reset values", $time);
    end

  a_sclk_parked: assert property (@(posedge clk) disable iff (!rst_n || !reset_applied)
    ss_n |-> sclk)
    else begin
      link_errs++;
      $display("ERROR at %0t ns: sclk low while ss_n is high", $time);
    end

  a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n || !reset_applied)
    rsp_valid |=> !rsp_valid)
    else begin
      rsp_errs++;
      $display("ERROR at %0t ns: rsp_valid held longer than one cycle", $time);
    end

  a_credit_range: assert property (@(posedge clk) disable iff (!rst_n || !reset_applied)
    (credits <= DEPTH) && (returned_total <= sent_total))
    else begin
      credit_errs++;
      $display("ERROR at %0t ns: credits %0d, returned %0d of %0d sent",
               $time, credits, returned_total, sent_total);
    end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    int total_errs;
    rst_n          = 1'b0;
    req_valid      = 1'b0;
    req            = '0;
    reset_applied  = 1'b0;
    lcg_state      = 32'hfb79_f363;
    credit_due     = 1'b0;
    credits        = DEPTH;                    // The host owns every queue slot after reset.
    sent_total     = 0;
    returned_total = 0;
    reset_errs     = 0;
    link_errs      = 0;
    rsp_errs       = 0;
    credit_errs    = 0;
    for (int a = 0; a < 128; a++) begin
      ref_regs[a] = 8'h00;
    end
    @(negedge clk);
    reset_applied = 1'b1;                      // The first rising edge has applied reset.
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      if (b % 2 == 0) begin
        while (credits != DEPTH) next_cycle(); // Even bursts fill an empty queue.
      end
      for (int n = 0; n < DEPTH; n++) begin
        next_cycle();
        while (credits == 0) next_cycle();
        lcg_state = lcg_step(lcg_state);
        send_request(lcg_state);
      end
    end
    next_cycle();
    while (exp_q.size() != 0 || credits != DEPTH) next_cycle();
    a_credit_total: assert (returned_total == sent_total) else begin
      credit_errs++;
      $display("ERROR at %0t ns: %0d credits returned for %0d requests",
               $time, returned_total, sent_total);
    end
    total_errs = reset_errs + link_errs + rsp_errs + credit_errs;
    $display("Errors: reset %0d, link %0d, response %0d, credit %0d",
             reset_errs, link_errs, rsp_errs, credit_errs);
    if (total_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+hw
hw/spi_link_pkg.sv
hw/host_req_pkg.sv
hw/spi_monarch.sv
hw/req_queue.sv
hw/spi_sequencer.sv
hw/spi_bridge_top.sv
tests/spi_serf_model.sv
tests/tb_spi_bridge.sv

/* run.sh */
#!/bin/sh
# Build the SPI bridge testbench with Verilator, run it, and pass only on the pass line.
verilator --binary --assert -Wno-fatal --top-module tb_spi_bridge -f all.f -o tb_spi_bridge \
  && out="$(./obj_dir/tb_spi_bridge)" \
  ; printf '%s\n' "$out" \
  ; printf '%s\n' "$out" | grep -q "All tests passed!" \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }
